// ==== common/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    parameter int XLEN       = 64;
    parameter int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

    // all zero is a bubble
    typedef struct packed {
        alu_op_e               alu_op;
        src_a_e                src_a;
        src_b_e                src_b;
        wb_sel_e               wb_sel;
        br_cond_e              br_cond;
        logic                  jal;
        logic                  jalr;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [2:0]            funct3;   // memory access size
        logic [REG_ADDR_W-1:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       result;      // alu value, mem address or link
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [2:0]            funct3;
        wb_sel_e               wb_sel;
    } ex_out_t;

endpackage

`default_nettype wire

// ==== design/instr_decoder.sv ====
`default_nettype none

module instr_decoder import rv_core_pkg::*; (
    input  logic [31:0]           instr_i,
    output ctrl_t                 ctrl_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  uses_rs1_o,
    output logic                  uses_rs2_o
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic                  shift_ok;
    logic                  op_ok;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;

    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic br_cond_e funct_to_br(input logic [2:0] f3);
        br_cond_e cond;
        case (f3)
            3'b000:  cond = BR_EQ;
            3'b001:  cond = BR_NE;
            3'b100:  cond = BR_LT;
            3'b101:  cond = BR_GE;
            3'b110:  cond = BR_LTU;
            3'b111:  cond = BR_GEU;
            default: cond = BR_NONE;
        endcase
        return cond;
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {{(XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    // rv64 shifts take a 6-bit shamt, so funct6 is checked
    assign shift_ok = (funct3 == 3'b001) ? (instr_i[31:26] == 6'b000000) :
                      (funct3 == 3'b101) ? (instr_i[31:26] == 6'b000000 ||
                                            instr_i[31:26] == 6'b010000) : 1'b1;
    assign op_ok = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        ctrl_o     = '0;   // unknown encodings stay a bubble
        imm_o      = '0;
        uses_rs1_o = 1'b0;
        uses_rs2_o = 1'b0;
        case (opcode)
            OPC_LUI: begin
                ctrl_o.alu_op    = ALU_PASS_B;
                ctrl_o.src_a     = SRC_A_ZERO;
                ctrl_o.src_b     = SRC_B_IMM;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.rd        = rd;
                imm_o            = imm_u;
            end
            OPC_AUIPC: begin
                ctrl_o.src_a     = SRC_A_PC;
                ctrl_o.src_b     = SRC_B_IMM;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.rd        = rd;
                imm_o            = imm_u;
            end
            OPC_JAL: begin
                ctrl_o.src_a     = SRC_A_PC;   // alu forms the target
                ctrl_o.src_b     = SRC_B_IMM;
                ctrl_o.wb_sel    = WB_PC4;
                ctrl_o.jal       = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.rd        = rd;
                imm_o            = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl_o.src_b     = SRC_B_IMM;
                    ctrl_o.wb_sel    = WB_PC4;
                    ctrl_o.jalr      = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.rd        = rd;
                    imm_o            = imm_i;
                    uses_rs1_o       = 1'b1;
                end
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    ctrl_o.src_a   = SRC_A_PC;
                    ctrl_o.src_b   = SRC_B_IMM;
                    ctrl_o.br_cond = funct_to_br(funct3);
                    imm_o          = imm_b;
                    uses_rs1_o     = 1'b1;
                    uses_rs2_o     = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 != 3'b111) begin
                    ctrl_o.src_b     = SRC_B_IMM;
                    ctrl_o.wb_sel    = WB_MEM;
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.funct3    = funct3;
                    ctrl_o.rd        = rd;
                    imm_o            = imm_i;
                    uses_rs1_o       = 1'b1;
                end
            end
            OPC_STORE: begin
                if (!funct3[2]) begin
                    ctrl_o.src_b     = SRC_B_IMM;
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.funct3    = funct3;
                    imm_o            = imm_s;
                    uses_rs1_o       = 1'b1;
                    uses_rs2_o       = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (shift_ok) begin
                    ctrl_o.alu_op    = funct_to_alu(funct3, funct3 == 3'b101 && instr_i[30]);
                    ctrl_o.src_b     = SRC_B_IMM;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.rd        = rd;
                    imm_o            = imm_i;
                    uses_rs1_o       = 1'b1;
                end
            end
            OPC_OP: begin
                if (op_ok) begin
                    ctrl_o.alu_op    = funct_to_alu(funct3, funct7[5]);
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.rd        = rd;
                    uses_rs1_o       = 1'b1;
                    uses_rs2_o       = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    output logic [XLEN-1:0]       rs1_val_o,
    output logic [XLEN-1:0]       rs2_val_o,
    input  logic                  wb_en_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];   // no storage for x0
    logic            wr_en;

    assign wr_en = wb_en_i && (wb_addr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && addr == wb_addr_i) begin
            val = wb_data_i;   // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val_o = read_port(rs1_i);
        rs2_val_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// ==== design/hazard_ctrl.sv ====
`default_nettype none

module hazard_ctrl import rv_core_pkg::*; (
    input  id_ex_t                id_ex_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic                  uses_rs1_i,
    input  logic                  uses_rs2_i,
    input  logic                  redirect_i,
    output logic                  stall_o,
    output logic                  clear_o
);

    logic                  load_in_ex;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  rs1_hit;
    logic                  rs2_hit;

    assign ex_rd = id_ex_i.ctrl.rd;

    // a load result is not ready until after mem, so the consumer waits
    assign load_in_ex = id_ex_i.valid && id_ex_i.ctrl.mem_read && (ex_rd != '0);

    assign rs1_hit = uses_rs1_i && (rs1_i == ex_rd);
    assign rs2_hit = uses_rs2_i && (rs2_i == ex_rd);

    assign stall_o = load_in_ex && (rs1_hit || rs2_hit);

    // stall inserts a bubble, redirect drops the wrong-path instr
    assign clear_o = stall_o || redirect_i;

endmodule

`default_nettype wire

// ==== design/id_ex_reg.sv ====
`default_nettype none

module id_ex_reg import rv_core_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   clear_i,
    input  id_ex_t d_i,
    output id_ex_t q_o
);

    // priority: reset, then clear, then capture
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_o <= '0;
        end else if (clear_i) begin
            q_o <= '0;   // bubble, valid low
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/ex_alu.sv ====
`default_nettype none

module ex_alu import rv_core_pkg::*; (
    input  id_ex_t          id_ex_i,
    output ex_out_t         ex_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic            taken;
    logic            valid;

    assign ctrl    = id_ex_i.ctrl;
    assign rs1_val = id_ex_i.rs1_val;
    assign rs2_val = id_ex_i.rs2_val;
    assign valid   = id_ex_i.valid;

    always_comb begin
        case (ctrl.src_a)
            SRC_A_PC:   op_a = id_ex_i.pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_val;
        endcase
    end

    assign op_b  = (ctrl.src_b == SRC_B_IMM) ? id_ex_i.imm : rs2_val;
    assign shamt = op_b[5:0];   // 64-bit shifts

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        case (ctrl.br_cond)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  taken = (rs1_val < rs2_val);
            BR_GEU:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = id_ex_i.pc + XLEN'(4);

    // branches and jal run pc+imm through the alu, jalr rs1+imm
    assign redirect_pc_o = ctrl.jalr ? {alu_res[XLEN-1:1], 1'b0} : alu_res;
    assign redirect_o    = valid && (taken || ctrl.jal || ctrl.jalr);

    always_comb begin
        ex_o            = '0;
        ex_o.valid      = valid;
        ex_o.result     = (ctrl.wb_sel == WB_PC4) ? pc_plus4 : alu_res;
        ex_o.store_data = rs2_val;
        ex_o.rd         = ctrl.rd;
        ex_o.reg_write  = valid && ctrl.reg_write;   // no side effects from a bubble
        ex_o.mem_read   = valid && ctrl.mem_read;
        ex_o.mem_write  = valid && ctrl.mem_write;
        ex_o.funct3     = ctrl.funct3;
        ex_o.wb_sel     = ctrl.wb_sel;
    end

endmodule

`default_nettype wire

// ==== design/id_ex_stage.sv ====
`default_nettype none

module id_ex_stage import rv_core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  if_valid_i,
    input  logic [31:0]           if_instr_i,
    input  logic [XLEN-1:0]       if_pc_i,
    input  logic                  wb_en_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output logic                  stall_o,
    output ex_out_t               ex_out_o,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o
);

    ctrl_t                 id_ctrl;
    logic [XLEN-1:0]       id_imm;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic                  id_uses_rs1;
    logic                  id_uses_rs2;
    logic [XLEN-1:0]       id_rs1_val;
    logic [XLEN-1:0]       id_rs2_val;
    logic                  id_ex_clear;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;

    instr_decoder u_decoder (
        .instr_i    (if_instr_i),
        .ctrl_o     (id_ctrl),
        .imm_o      (id_imm),
        .rs1_o      (id_rs1),
        .rs2_o      (id_rs2),
        .uses_rs1_o (id_uses_rs1),
        .uses_rs2_o (id_uses_rs2)
    );

    reg_file u_reg_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs1_i     (id_rs1),
        .rs2_i     (id_rs2),
        .rs1_val_o (id_rs1_val),
        .rs2_val_o (id_rs2_val),
        .wb_en_i   (wb_en_i),
        .wb_addr_i (wb_addr_i),
        .wb_data_i (wb_data_i)
    );

    assign id_ex_d.valid   = if_valid_i;
    assign id_ex_d.ctrl    = id_ctrl;
    assign id_ex_d.pc      = if_pc_i;
    assign id_ex_d.imm     = id_imm;
    assign id_ex_d.rs1_val = id_rs1_val;
    assign id_ex_d.rs2_val = id_rs2_val;
    assign id_ex_d.rs1     = id_rs1;
    assign id_ex_d.rs2     = id_rs2;

    hazard_ctrl u_hazard (
        .id_ex_i    (id_ex_q),
        .rs1_i      (id_rs1),
        .rs2_i      (id_rs2),
        .uses_rs1_i (id_uses_rs1),
        .uses_rs2_i (id_uses_rs2),
        .redirect_i (redirect_o),
        .stall_o    (stall_o),
        .clear_o    (id_ex_clear)
    );

    id_ex_reg u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (id_ex_clear),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    ex_alu u_ex (
        .id_ex_i       (id_ex_q),
        .ex_o          (ex_out_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

`default_nettype wire

// ==== test/id_ex_props.sv ====
`default_nettype none

module id_ex_props import rv_core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  id_ex_t      q_i,
    input  logic [31:0] instr_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [6:0]            opc;
    logic                  reads_rs1;
    logic                  reads_rs2;
    logic [REG_ADDR_W-1:0] ld_rd;
    logic                  ld_hit;

    assign opc = instr_i[6:0];

    // register sources by major opcode
    assign reads_rs1 = opc inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
    assign reads_rs2 = opc inside {OPC_BRANCH, OPC_STORE, OPC_OP};

    assign ld_rd  = q_i.ctrl.rd;
    assign ld_hit = q_i.valid && q_i.ctrl.mem_read && (ld_rd != '0) &&
                    ((reads_rs1 && instr_i[19:15] == ld_rd) ||
                     (reads_rs2 && instr_i[24:20] == ld_rd));

    // a flushed or stalled slot must be a bubble next cycle
    a_flush_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i || redirect_i) |=> !q_i.valid)
        else $error("ID/EX entry valid after stall or redirect");

    a_stall_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> ld_hit)
        else $error("stall without a matching load in EX");

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> (!q_i.valid && !stall_i && !redirect_i))
        else $error("outputs active after reset");

endmodule

bind id_ex_stage id_ex_props u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_o),
    .redirect_i (redirect_o),
    .q_i        (id_ex_q),
    .instr_i    (if_instr_i)
);

`default_nettype wire

// ==== test/tb_id_ex_stage.sv ====
`default_nettype none

module tb_id_ex_stage import rv_core_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]     instr;
        logic [XLEN-1:0] pc;
        logic            wb_en;
        logic [4:0]      wb_addr;
        logic [XLEN-1:0] wb_data;
        logic            stall;
        logic            redir;
        logic [XLEN-1:0] target;
        logic            ex_exp;   // low for discarded shadow slots
    } entry_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  if_valid_i;
    logic [31:0]           if_instr_i;
    logic [XLEN-1:0]       if_pc_i;
    logic                  wb_en_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [XLEN-1:0]       wb_data_i;
    logic                  stall_o;
    ex_out_t               ex_out_o;
    logic                  redirect_o;
    logic [XLEN-1:0]       redirect_pc_o;

    entry_t          tbl[$];
    logic [XLEN-1:0] model[0:31];
    logic [31:0]     lfsr;
    logic [XLEN-1:0] next_pc;
    int              errors;
    int              checks;
    int              cycles;
    int              limit;

    id_ex_stage i_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .if_valid_i    (if_valid_i),
        .if_instr_i    (if_instr_i),
        .if_pc_i       (if_pc_i),
        .wb_en_i       (wb_en_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .stall_o       (stall_o),
        .ex_out_o      (ex_out_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            errors = errors + 1;
            $display("timeout: run went past %0d cycles", limit);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand64(output logic [XLEN-1:0] v);
        for (int b = 0; b < XLEN; b++) begin
            lfsr = lfsr_next(lfsr);
            v[b] = lfsr[0];
        end
    endtask

    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {63'd0, $signed(a) < $signed(b)};
            3'b011:  return {63'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? XLEN'($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA result of one instruction against the model registers
    function automatic logic [XLEN-1:0] ref_result(input logic [31:0] ins,
                                                   input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_s;
        logic [XLEN-1:0] imm_u;
        a     = model[ins[19:15]];
        b     = model[ins[24:20]];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'd0};
        case (ins[6:0])
            OPC_LUI:           return imm_u;
            OPC_AUIPC:         return pc + imm_u;
            OPC_JAL, OPC_JALR: return pc + 64'd4;
            OPC_LOAD:          return a + imm_i;
            OPC_STORE:         return a + imm_s;
            OPC_OP_IMM:        return ref_alu(ins[14:12], ins[14:12] == 3'b101 && ins[30],
                                              a, imm_i);
            OPC_OP:            return ref_alu(ins[14:12], ins[30], a, b);
            default:           return '0;
        endcase
    endfunction

    task automatic check(input logic ok, input string what);
        checks = checks + 1;
        assert (ok) else begin
            $display("FAILED %0t ns: %s", $time, what);
            errors = errors + 1;
        end
    endtask

    task automatic add(input logic [31:0] instr, input logic stall = 1'b0,
                       input logic redir = 1'b0, input int off = 0,
                       input logic wb_en = 1'b0, input int wb_addr = 0,
                       input logic [XLEN-1:0] wb_data = 64'd0);
        entry_t e;
        e = '{instr, next_pc, wb_en, wb_addr[4:0], wb_data, stall, redir,
              next_pc + 64'(off), 1'b1};
        tbl.push_back(e);
        next_pc = next_pc + 64'd4;
        if (redir) begin   // wrong-path slot behind the jump
            e = '{i_type(1, 1, 0, 26, OPC_OP_IMM), next_pc, 1'b0, 5'd0, 64'd0, 1'b0, 1'b0,
                  64'd0, 1'b0};
            tbl.push_back(e);
            next_pc = next_pc + 64'd4;
        end
    endtask

    task automatic build_table();
        next_pc = 64'h1000;
        for (int f = 0; f < 8; f++) begin
            add(r_type(0, f + 2, f + 1, f, 20));
        end
        add(r_type(32, 4, 3, 0, 20));   // sub
        add(r_type(32, 10, 9, 5, 20));  // sra
        add(i_type(-5, 1, 0, 21, OPC_OP_IMM));
        add(i_type(100, 2, 2, 21, OPC_OP_IMM));
        add(i_type(-1, 3, 3, 21, OPC_OP_IMM));
        add(i_type(1365, 4, 4, 21, OPC_OP_IMM));
        add(i_type(-256, 5, 6, 21, OPC_OP_IMM));
        add(i_type(2047, 6, 7, 21, OPC_OP_IMM));
        add(i_type(63, 7, 1, 21, OPC_OP_IMM));
        add(i_type(33, 8, 5, 21, OPC_OP_IMM));
        add(i_type('h400 | 40, 9, 5, 21, OPC_OP_IMM));
        add(u_type('hfffff, 22, OPC_LUI));
        add(u_type('h12345, 22, OPC_AUIPC));
        add(j_type(16, 1), 1'b0, 1'b1, 16);
        add(i_type(256, 0, 0, 5, OPC_JALR), 1'b0, 1'b1, 256 - int'(next_pc));
        add(b_type(-8, 1, 1, 0), 1'b0, 1'b1, -8);    // beq taken
        add(b_type(-8, 1, 0, 0));                    // beq not taken
        add(b_type(12, 1, 0, 1), 1'b0, 1'b1, 12);    // bne
        add(b_type(12, 1, 1, 1));
        add(b_type(20, 1, 1, 4));                    // blt
        add(b_type(20, 0, 10, 4), 1'b0, 1'b1, 20, 1'b1, 10, 64'hffff_ffff_ffff_fff0);
        add(b_type(20, 1, 1, 5), 1'b0, 1'b1, 20);    // bge
        add(b_type(20, 0, 10, 5));
        add(b_type(24, 1, 1, 6));                    // bltu
        add(b_type(24, 1, 0, 6), 1'b0, 1'b1, 24);
        add(b_type(28, 1, 1, 7), 1'b0, 1'b1, 28);    // bgeu
        add(b_type(28, 1, 0, 7));
        add(i_type(8, 1, 3, 16, OPC_LOAD));          // ld x16 then use
        add(r_type(0, 2, 16, 0, 23), 1'b1);
        add(i_type(0, 2, 3, 17, OPC_LOAD));
        add(r_type(0, 2, 1, 0, 23));
        add(i_type(4, 3, 2, 18, OPC_LOAD));
        add(s_type(0, 18, 4, 3), 1'b1);              // rs2 side hazard
        add(r_type(0, 0, 0, 0, 24), 1'b0, 1'b0, 0, 1'b1, 0, 64'hdead_beef);
        add(r_type(0, 1, 0, 0, 24));
        add(r_type(0, 0, 7, 0, 24), 1'b0, 1'b0, 0, 1'b1, 7, 64'h55aa_33cc_0f0f_1234);
        add(s_type(16, 5, 6, 3));
        add(s_type(-3, 7, 8, 0));
        add(i_type(7, 9, 4, 25, OPC_LOAD));
    endtask

    task automatic check_ex(input entry_t e, input logic [XLEN-1:0] res,
                            input logic [XLEN-1:0] sd);
        logic [6:0] op;
        logic       mem;
        logic       wr;
        wb_sel_e    wb;
        op  = e.instr[6:0];
        mem = (op == OPC_LOAD) || (op == OPC_STORE);
        wr  = (op != OPC_STORE) && (op != OPC_BRANCH);
        wb  = (op == OPC_LOAD) ? WB_MEM :
              (op == OPC_JAL || op == OPC_JALR) ? WB_PC4 : WB_ALU;
        check(redirect_o == e.redir, $sformatf("redirect %b at pc %h", redirect_o, e.pc));
        if (e.redir) begin
            check(redirect_pc_o == e.target,
                  $sformatf("target %h, expected %h", redirect_pc_o, e.target));
        end
        if (!e.ex_exp) begin
            check(!ex_out_o.valid, $sformatf("discarded pc %h reached EX", e.pc));
        end else begin
            check(ex_out_o.valid, $sformatf("no EX output for pc %h", e.pc));
            if (op != OPC_BRANCH) begin
                check(ex_out_o.result == res,
                      $sformatf("result %h, expected %h", ex_out_o.result, res));
            end
            check(ex_out_o.reg_write == wr, "reg_write");
            check(ex_out_o.rd == (wr ? e.instr[11:7] : 5'd0), "rd");
            check(ex_out_o.mem_read == (op == OPC_LOAD), "mem_read");
            check(ex_out_o.mem_write == (op == OPC_STORE), "mem_write");
            check(ex_out_o.funct3 == (mem ? e.instr[14:12] : 3'd0), "funct3");
            check(ex_out_o.wb_sel == wb, $sformatf("wb_sel at pc %h", e.pc));
            if (op == OPC_STORE) begin
                check(ex_out_o.store_data == sd, "store_data");
            end
        end
    endtask

    initial begin
        entry_t          e;
        logic [XLEN-1:0] v;
        logic [XLEN-1:0] pend_res;
        logic [XLEN-1:0] pend_sd;
        int              n;
        rst_n_i    = 1'b0;
        if_valid_i = 1'b0;
        if_instr_i = '0;
        if_pc_i    = '0;
        wb_en_i    = 1'b0;
        wb_addr_i  = '0;
        wb_data_i  = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        limit      = 1000;
        lfsr       = 32'd76915;
        pend_res   = '0;
        pend_sd    = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        build_table();
        n     = tbl.size();
        limit = 2 * n + 8 + 16 + 20;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int r = 1; r < 16; r++) begin
            rand64(v);
            v = v | 64'd1;   // keep x1 to x15 non-zero
            @(posedge clk_i);
            wb_en_i   <= 1'b1;
            wb_addr_i <= r[4:0];
            wb_data_i <= v;
            model[r]  = v;
        end
        for (int i = 0; i <= n; i++) begin
            @(posedge clk_i);
            if (i < n) begin
                e = tbl[i];
                if_valid_i <= 1'b1;
                if_instr_i <= e.instr;
                if_pc_i    <= e.pc;
                wb_en_i    <= e.wb_en;
                wb_addr_i  <= e.wb_addr;
                wb_data_i  <= e.wb_data;
                if (e.wb_en && e.wb_addr != 5'd0) begin
                    model[e.wb_addr] = e.wb_data;
                end
            end else begin
                if_valid_i <= 1'b0;
                wb_en_i    <= 1'b0;
            end
            @(negedge clk_i);
            if (i > 0) begin
                check_ex(tbl[i-1], pend_res, pend_sd);
            end
            if (i < n) begin
                check(stall_o == e.stall, $sformatf("stall %b at pc %h", stall_o, e.pc));
                pend_res = ref_result(e.instr, e.pc);
                pend_sd  = model[e.instr[24:20]];
                if (e.stall) begin   // fetch holds the instr one cycle
                    @(posedge clk_i);
                    wb_en_i <= 1'b0;
                    @(negedge clk_i);
                    check(!ex_out_o.valid, "no bubble after stall");
                    check(!stall_o, "stall longer than one cycle");
                    check(!redirect_o, "redirect from bubble");
                end
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/rv_core_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/hazard_ctrl.sv
design/id_ex_reg.sv
design/ex_alu.sv
design/id_ex_stage.sv
test/id_ex_props.sv
test/tb_id_ex_stage.sv

// ==== Makefile ====
# Verilator build and run of the ID/EX slice testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f flist.f --top-module tb_id_ex_stage -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
